// File: cachePkg.sv
// Cache control shared types
`default_nettype none

package cachePkg;

  // Fixed four-way organization
  parameter int NumWays = 4;

  // One bit per way
  typedef logic [NumWays-1:0] wayMaskT;

  // Way number, also the LRU code
  typedef logic [$clog2(NumWays)-1:0] wayIdxT;

  // Cycle type held for the running cache cycle
  typedef enum logic [1:0] {
    cycIdle = 2'd0,
    cycChan = 2'd1,
    cycEbox = 2'd2,
    cycCca  = 2'd3
  } cycTypeE;

endpackage

`default_nettype wire

// File: reqArbiter.sv
// Cache request arbiter
`timescale 1ns/1ps
`default_nettype none

module reqArbiter (
  input  var logic             clk,
  input  var logic             rstN,
  input  var logic             chanReq,
  input  var logic             eboxReq,
  input  var logic             ccaReq,
  input  var logic             readyToGo,
  output var logic             chanGrant,
  output var logic             eboxGrant,
  output var logic             ccaGrant,
  output var cachePkg::cycTypeE cycType
);

  import cachePkg::*;

  logic anyGrant;

  // Channel first, then EBOX, CCA last
  always_comb begin
    chanGrant = readyToGo & chanReq;
    eboxGrant = readyToGo & eboxReq & ~chanReq;
    ccaGrant  = readyToGo & ccaReq & ~chanReq & ~eboxReq;
  end

  assign anyGrant = chanGrant | eboxGrant | ccaGrant;

  // Cycle type loads with the grant and holds until the cache is ready again
  always_ff @(posedge clk) begin
    if (!rstN) begin
      cycType <= cycIdle;
    end else if (anyGrant) begin
      if (chanGrant) begin
        cycType <= cycChan;
      end else if (eboxGrant) begin
        cycType <= cycEbox;
      end else begin
        cycType <= cycCca;
      end
    end else if (readyToGo) begin
      cycType <= cycIdle;
    end
  end

endmodule

`default_nettype wire

// File: wayMatch.sv
// Way match and victim evaluation
`timescale 1ns/1ps
`default_nettype none

module wayMatch (
  input  var logic             clk,
  input  var logic             rstN,
  input  var logic             lookupT2,
  input  var cachePkg::wayMaskT validMatch,
  input  var cachePkg::wayMaskT anyWritten,
  input  var cachePkg::wayMaskT wordValid,
  input  var cachePkg::wayIdxT  lru,
  output var logic             anyValid,
  output var logic             rdFound,
  output var logic             writtenMatch,
  output var logic             victimDirty,
  output var cachePkg::wayIdxT  matchWay,
  output var cachePkg::wayIdxT  victimWay
);

  import cachePkg::*;

  logic   anyValidNxt;
  logic   rdFoundNxt;
  logic   writtenMatchNxt;
  logic   victimDirtyNxt;
  wayIdxT matchWayNxt;

  // Per-way reductions
  always_comb begin
    anyValidNxt     = |validMatch;
    rdFoundNxt      = |(validMatch & wordValid);
    writtenMatchNxt = |(validMatch & anyWritten);
    victimDirtyNxt  = anyWritten[lru];
  end

  // Lowest-numbered matching way wins
  always_comb begin
    matchWayNxt = '0;
    for (int i = NumWays - 1; i >= 0; i--) begin
      if (validMatch[i]) begin
        matchWayNxt = wayIdxT'(i);
      end
    end
  end

  // Status flags, valid in T3
  always_ff @(posedge clk) begin
    if (!rstN) begin
      anyValid     <= 1'b0;
      rdFound      <= 1'b0;
      writtenMatch <= 1'b0;
      victimDirty  <= 1'b0;
    end else if (lookupT2) begin
      anyValid     <= anyValidNxt;
      rdFound      <= rdFoundNxt;
      writtenMatch <= writtenMatchNxt;
      victimDirty  <= victimDirtyNxt;
    end
  end

  // Way numbers held until the next lookup
  always_ff @(posedge clk) begin
    if (lookupT2) begin
      matchWay  <= matchWayNxt;
      victimWay <= lru;
    end
  end

endmodule

`default_nettype wire

// File: cycleSeq.sv
// Cache cycle sequencer
`timescale 1ns/1ps
`default_nettype none

module cycleSeq (
  input  var logic             clk,
  input  var logic             rstN,
  input  var logic             chanGrant,
  input  var logic             eboxGrant,
  input  var logic             ccaGrant,
  input  var cachePkg::cycTypeE cycType,
  input  var logic             vmaRead,
  input  var logic             cacheBit,
  input  var logic             coreBusy,
  input  var logic             coreDataValid,
  input  var logic             anyValid,
  input  var logic             rdFound,
  input  var logic             writtenMatch,
  input  var logic             victimDirty,
  input  var cachePkg::wayIdxT  matchWay,
  input  var cachePkg::wayIdxT  victimWay,
  output var logic             readyToGo,
  output var logic             lookupT2,
  output var logic             coreRdReq,
  output var logic             eboxResp,
  output var logic             cacheWr,
  output var logic             coreWrReq,
  output var logic             writeback,
  output var logic             retryReq,
  output var logic             chanHit,
  output var logic             ccaInval,
  output var cachePkg::wayIdxT  hitWay
);

  import cachePkg::*;

  logic anyGrant;
  logic t1;
  logic t2;
  logic t3;
  logic busyT2;
  logic fillCache;
  logic coreRdPend;
  logic rdDone;

  logic eboxRdT3;
  logic eboxWrT3;
  logic rdHit;
  logic rdMiss;
  logic wrHit;
  logic wrMiss;
  logic missBusy;
  logic missDirty;
  logic startRd;
  logic wrAlloc;
  logic wrCore;
  logic ccaT3;
  logic ccaWb;

  assign anyGrant = chanGrant | eboxGrant | ccaGrant;

  // Timing chain, grant cycle is T0
  always_ff @(posedge clk) begin
    if (!rstN) begin
      t1 <= 1'b0;
      t2 <= 1'b0;
      t3 <= 1'b0;
    end else begin
      t1 <= anyGrant;
      t2 <= t1;
      t3 <= t2;
    end
  end

  assign lookupT2 = t2;

  // Core status taken with the lookup
  always_ff @(posedge clk) begin
    if (!rstN) begin
      busyT2 <= 1'b0;
    end else if (t2) begin
      busyT2 <= coreBusy;
    end
  end

  // T3 outcome decode
  always_comb begin
    eboxRdT3 = t3 & (cycType == cycEbox) & vmaRead;
    eboxWrT3 = t3 & (cycType == cycEbox) & ~vmaRead;

    rdHit  = eboxRdT3 & rdFound;
    rdMiss = eboxRdT3 & ~rdFound;
    wrHit  = eboxWrT3 & anyValid;
    wrMiss = eboxWrT3 & ~anyValid;

    // Busy core turns any miss into a plain retry
    missBusy  = (rdMiss | wrMiss) & busyT2;
    missDirty = (rdMiss | wrMiss) & ~busyT2 & cacheBit & victimDirty;

    startRd = rdMiss & ~busyT2 & ~(cacheBit & victimDirty);
    wrAlloc = wrMiss & ~busyT2 & cacheBit & ~victimDirty;
    wrCore  = wrMiss & ~busyT2 & ~cacheBit;

    ccaT3 = t3 & (cycType == cycCca);
    ccaWb = ccaT3 & anyValid & writtenMatch;
  end

  // Core read stays requested until data arrives
  assign coreRdReq = startRd | coreRdPend;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      coreRdPend <= 1'b0;
      rdDone     <= 1'b0;
    end else begin
      coreRdPend <= coreRdReq & ~coreDataValid;
      rdDone     <= coreRdReq & coreDataValid;
    end
  end

  // Whether the returned word goes into the cache
  always_ff @(posedge clk) begin
    if (!rstN) begin
      fillCache <= 1'b0;
    end else if (t3) begin
      fillCache <= cacheBit;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      readyToGo <= 1'b1;
    end else if (anyGrant) begin
      readyToGo <= 1'b0;
    end else if ((t3 & ~startRd) | rdDone) begin
      readyToGo <= 1'b1;
    end
  end

  // Result pulses
  always_comb begin
    eboxResp  = rdHit | wrHit | wrAlloc | wrCore | rdDone;
    cacheWr   = wrHit | wrAlloc | (rdDone & fillCache);
    coreWrReq = wrCore;
    writeback = missDirty | ccaWb;
    retryReq  = missBusy | missDirty;
    chanHit   = t3 & (cycType == cycChan) & anyValid;
    ccaInval  = ccaT3 & anyValid & ~writtenMatch;
  end

  // Victim way for fills and miss writebacks, matched way otherwise
  always_comb begin
    if (rdDone | missDirty | wrAlloc) begin
      hitWay = victimWay;
    end else begin
      hitWay = matchWay;
    end
  end

endmodule

`default_nettype wire

// File: cacheCtl.sv
// Cache control top level
`timescale 1ns/1ps
`default_nettype none

module cacheCtl (
  input  var logic             clk,
  input  var logic             rstN,
  input  var logic             chanReq,
  input  var logic             eboxReq,
  input  var logic             ccaReq,
  input  var logic             vmaRead,
  input  var logic             cacheBit,
  input  var cachePkg::wayMaskT validMatch,
  input  var cachePkg::wayMaskT anyWritten,
  input  var cachePkg::wayMaskT wordValid,
  input  var cachePkg::wayIdxT  lru,
  input  var logic             coreBusy,
  input  var logic             coreDataValid,
  output var logic             chanGrant,
  output var logic             eboxGrant,
  output var logic             ccaGrant,
  output var logic             readyToGo,
  output var logic             coreRdReq,
  output var logic             eboxResp,
  output var logic             cacheWr,
  output var logic             coreWrReq,
  output var logic             writeback,
  output var logic             retryReq,
  output var logic             chanHit,
  output var logic             ccaInval,
  output var cachePkg::wayIdxT  hitWay
);

  import cachePkg::*;

  cycTypeE cycType;
  logic    lookupT2;
  logic    anyValid;
  logic    rdFound;
  logic    writtenMatch;
  logic    victimDirty;
  wayIdxT  matchWay;
  wayIdxT  victimWay;

  reqArbiter uArb (
    .clk       (clk),
    .rstN      (rstN),
    .chanReq   (chanReq),
    .eboxReq   (eboxReq),
    .ccaReq    (ccaReq),
    .readyToGo (readyToGo),
    .chanGrant (chanGrant),
    .eboxGrant (eboxGrant),
    .ccaGrant  (ccaGrant),
    .cycType   (cycType)
  );

  // Runs beside the arbiter, strobed at T2
  wayMatch uMatch (
    .clk          (clk),
    .rstN         (rstN),
    .lookupT2     (lookupT2),
    .validMatch   (validMatch),
    .anyWritten   (anyWritten),
    .wordValid    (wordValid),
    .lru          (lru),
    .anyValid     (anyValid),
    .rdFound      (rdFound),
    .writtenMatch (writtenMatch),
    .victimDirty  (victimDirty),
    .matchWay     (matchWay),
    .victimWay    (victimWay)
  );

  cycleSeq uSeq (
    .clk           (clk),
    .rstN          (rstN),
    .chanGrant     (chanGrant),
    .eboxGrant     (eboxGrant),
    .ccaGrant      (ccaGrant),
    .cycType       (cycType),
    .vmaRead       (vmaRead),
    .cacheBit      (cacheBit),
    .coreBusy      (coreBusy),
    .coreDataValid (coreDataValid),
    .anyValid      (anyValid),
    .rdFound       (rdFound),
    .writtenMatch  (writtenMatch),
    .victimDirty   (victimDirty),
    .matchWay      (matchWay),
    .victimWay     (victimWay),
    .readyToGo     (readyToGo),
    .lookupT2      (lookupT2),
    .coreRdReq     (coreRdReq),
    .eboxResp      (eboxResp),
    .cacheWr       (cacheWr),
    .coreWrReq     (coreWrReq),
    .writeback     (writeback),
    .retryReq      (retryReq),
    .chanHit       (chanHit),
    .ccaInval      (ccaInval),
    .hitWay        (hitWay)
  );

endmodule

`default_nettype wire

// File: tbCacheCtl.sv
// Cache control testbench
`timescale 1ns/1ps
`default_nettype none

module tbCacheCtl;

  import cachePkg::*;

  localparam int TimeoutCycles = 2000;

  // Result pulse positions in the packed pulse vector
  localparam logic [6:0] PResp   = 7'b1000000;
  localparam logic [6:0] PWr     = 7'b0100000;
  localparam logic [6:0] PCoreWr = 7'b0010000;
  localparam logic [6:0] PWb     = 7'b0001000;
  localparam logic [6:0] PRetry  = 7'b0000100;
  localparam logic [6:0] PChan   = 7'b0000010;
  localparam logic [6:0] PInval  = 7'b0000001;

  logic    clk;
  logic    rstN;
  logic    chanReq, eboxReq, ccaReq;
  logic    vmaRead, cacheBit, coreBusy, coreDataValid;
  wayMaskT validMatch, anyWritten, wordValid;
  wayIdxT  lru;
  logic    chanGrant, eboxGrant, ccaGrant;
  logic    readyToGo, coreRdReq;
  logic    eboxResp, cacheWr, coreWrReq, writeback, retryReq, chanHit, ccaInval;
  wayIdxT  hitWay;
  int      errorCount;
  int      cycleCount;

  cacheCtl UUT (
    .clk           (clk),
    .rstN          (rstN),
    .chanReq       (chanReq),
    .eboxReq       (eboxReq),
    .ccaReq        (ccaReq),
    .vmaRead       (vmaRead),
    .cacheBit      (cacheBit),
    .validMatch    (validMatch),
    .anyWritten    (anyWritten),
    .wordValid     (wordValid),
    .lru           (lru),
    .coreBusy      (coreBusy),
    .coreDataValid (coreDataValid),
    .chanGrant     (chanGrant),
    .eboxGrant     (eboxGrant),
    .ccaGrant      (ccaGrant),
    .readyToGo     (readyToGo),
    .coreRdReq     (coreRdReq),
    .eboxResp      (eboxResp),
    .cacheWr       (cacheWr),
    .coreWrReq     (coreWrReq),
    .writeback     (writeback),
    .retryReq      (retryReq),
    .chanHit       (chanHit),
    .ccaInval      (ccaInval),
    .hitWay        (hitWay)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    cycleCount = 0;
    while (cycleCount < TimeoutCycles) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout after %0d cycles, the DUT never answered a request", cycleCount);
    $display("Errors found");
    $fatal(1, "Run stopped by timeout");
  end

  task automatic checkEq(input string testName, input logic [31:0] expVal,
                         input logic [31:0] actVal);
    if (expVal !== actVal) begin
      errorCount++;
      $display("ERR %s expected %0h actual %0h", testName, expVal, actVal);
      $display("Errors found");
      $fatal(1, "Mismatch in %s", testName);
    end
  endtask

  function automatic logic [6:0] pulses();
    return {eboxResp, cacheWr, coreWrReq, writeback, retryReq, chanHit, ccaInval};
  endfunction

  function automatic wayMaskT randMask();
    return wayMaskT'($urandom);
  endfunction

  function automatic wayMaskT wayBit(input wayIdxT w);
    return wayMaskT'(1) << w;
  endfunction

  // Lowest-numbered set way of a mask
  function automatic wayIdxT lowestWay(input wayMaskT m);
    wayIdxT w;
    logic   found;
    w = '0;
    found = 1'b0;
    for (int i = 0; i < NumWays; i++) begin
      if (m[i] && !found) begin
        w = wayIdxT'(i);
        found = 1'b1;
      end
    end
    return w;
  endfunction

  // Waits for ready, requests, checks the grant and returns at mid T3
  task automatic runCycle(input cycTypeE who, input string testName, input wayMaskT vm,
                          input wayMaskT aw, input wayMaskT wv, input wayIdxT lruVal,
                          input logic rd, input logic cacheable, input logic busy);
    logic [2:0] expGrant;
    @(posedge clk);
    #1;
    while (!readyToGo) begin
      @(posedge clk);
      #1;
    end
    validMatch = vm;
    anyWritten = aw;
    wordValid  = wv;
    lru        = lruVal;
    vmaRead    = rd;
    cacheBit   = cacheable;
    coreBusy   = busy;
    case (who)
      cycChan: expGrant = 3'b100;
      cycEbox: expGrant = 3'b010;
      default: expGrant = 3'b001;
    endcase
    {chanReq, eboxReq, ccaReq} = expGrant;
    @(negedge clk);
    checkEq({testName, " grant"}, expGrant, {chanGrant, eboxGrant, ccaGrant});
    @(posedge clk);
    #1;
    {chanReq, eboxReq, ccaReq} = 3'b000;
    repeat (2) @(posedge clk);
    @(negedge clk);
  endtask

  // One cycle without core read, checked at T3 and in the cycle after
  task automatic runAndCheck(input cycTypeE who, input string testName, input wayMaskT vm,
                             input wayMaskT aw, input wayMaskT wv, input wayIdxT lruVal,
                             input logic rd, input logic cacheable, input logic busy,
                             input logic [6:0] expPulses, input logic wayKnown,
                             input wayIdxT expWay);
    runCycle(who, testName, vm, aw, wv, lruVal, rd, cacheable, busy);
    checkEq({testName, " pulses"}, expPulses, pulses());
    checkEq({testName, " coreRdReq"}, 0, coreRdReq);
    if (wayKnown) begin
      checkEq({testName, " hitWay"}, expWay, hitWay);
    end
    @(negedge clk);
    checkEq({testName, " ready after"}, 1, readyToGo);
    checkEq({testName, " pulses after"}, 0, pulses());
  endtask

  // Counts cycles until the next grant
  task automatic waitGrant(output int gap);
    gap = 1;
    @(negedge clk);
    while (!(chanGrant | eboxGrant | ccaGrant)) begin
      @(negedge clk);
      gap++;
    end
  endtask

  task automatic testResetPriority();
    int gap;
    @(negedge clk);
    checkEq("reset ready", 1, readyToGo);
    checkEq("reset pulses", 0, pulses());
    checkEq("reset grants", 0, {chanGrant, eboxGrant, ccaGrant});
    checkEq("reset coreRdReq", 0, coreRdReq);
    checkEq("reset cycType", cycIdle, UUT.uArb.cycType);
    @(posedge clk);
    #1;
    // EBOX read hit, so no cycle starts a core read
    validMatch = 4'b0010;
    wordValid  = 4'b0010;
    vmaRead    = 1'b1;
    {chanReq, eboxReq, ccaReq} = 3'b111;
    @(negedge clk);
    checkEq("priority chan", 3'b100, {chanGrant, eboxGrant, ccaGrant});
    @(posedge clk);
    #1;
    chanReq = 1'b0;
    waitGrant(gap);
    checkEq("priority ebox", 3'b010, {chanGrant, eboxGrant, ccaGrant});
    checkEq("priority ebox gap", 4, gap);
    @(posedge clk);
    #1;
    eboxReq = 1'b0;
    waitGrant(gap);
    checkEq("priority cca", 3'b001, {chanGrant, eboxGrant, ccaGrant});
    checkEq("priority cca gap", 4, gap);
    @(posedge clk);
    #1;
    ccaReq = 1'b0;
  endtask

  task automatic testReadHit();
    wayIdxT  k;
    wayMaskT vm;
    k  = wayIdxT'($urandom);
    vm = randMask() | wayBit(k);
    runAndCheck(cycEbox, "read hit", vm, randMask(), randMask() | wayBit(k),
                wayIdxT'($urandom), 1'b1, 1'($urandom_range(0, 1)),
                1'($urandom_range(0, 1)), PResp, 1'b1, lowestWay(vm));
  endtask

  task automatic testReadMiss();
    wayIdxT  lruVal;
    wayMaskT vm;
    int      extra;
    // Victim way kept apart from any matched way
    lruVal = wayIdxT'($urandom_range(1, NumWays - 1));
    vm     = randMask() & ~wayBit(lruVal);
    extra  = $urandom_range(0, 4);
    runCycle(cycEbox, "read miss", vm, randMask() & ~wayBit(lruVal), randMask() & ~vm,
             lruVal, 1'b1, 1'b1, 1'b0);
    checkEq("read miss T3 pulses", 0, pulses());
    checkEq("read miss coreRdReq", 1, coreRdReq);
    repeat (extra) begin
      @(negedge clk);
      checkEq("read miss wait coreRdReq", 1, coreRdReq);
      checkEq("read miss wait pulses", 0, pulses());
    end
    @(posedge clk);
    #1;
    coreDataValid = 1'b1;
    @(negedge clk);
    checkEq("read miss data coreRdReq", 1, coreRdReq);
    @(posedge clk);
    #1;
    coreDataValid = 1'b0;
    @(negedge clk);
    checkEq("read miss fill pulses", PResp | PWr, pulses());
    checkEq("read miss fill hitWay", lruVal, hitWay);
    checkEq("read miss fill coreRdReq", 0, coreRdReq);
    checkEq("read miss fill ready", 0, readyToGo);
    @(negedge clk);
    checkEq("read miss ready", 1, readyToGo);
    checkEq("read miss idle pulses", 0, pulses());
  endtask

  task automatic testWrites();
    wayIdxT  k;
    wayIdxT  lruVal;
    wayMaskT vm;
    k      = wayIdxT'($urandom);
    // Nonzero victim so it differs from the matched way of an empty mask
    lruVal = wayIdxT'($urandom_range(1, NumWays - 1));
    vm     = randMask() | wayBit(k);
    runAndCheck(cycEbox, "write hit", vm, randMask(), randMask(), lruVal, 1'b0,
                1'($urandom_range(0, 1)), 1'($urandom_range(0, 1)), PResp | PWr, 1'b1,
                lowestWay(vm));
    runAndCheck(cycEbox, "write allocate", '0, randMask() & ~wayBit(lruVal), randMask(),
                lruVal, 1'b0, 1'b1, 1'b0, PResp | PWr, 1'b1, lruVal);
    runAndCheck(cycEbox, "write uncached", '0, randMask(), randMask(), lruVal, 1'b0, 1'b0,
                1'b0, PResp | PCoreWr, 1'b0, '0);
    runAndCheck(cycEbox, "write dirty", '0, randMask() | wayBit(lruVal), randMask(),
                lruVal, 1'b0, 1'b1, 1'b0, PWb | PRetry, 1'b1, lruVal);
    runAndCheck(cycEbox, "write busy", '0, randMask(), randMask(), lruVal, 1'b0,
                1'($urandom_range(0, 1)), 1'b1, PRetry, 1'b0, '0);
  endtask

  task automatic testChanCca();
    wayIdxT  k;
    wayMaskT vm;
    for (int i = 0; i < 3; i++) begin
      vm = (i == 0) ? '0 : randMask();
      if (i == 2) begin
        vm = vm | wayBit(wayIdxT'($urandom));
      end
      runAndCheck(cycChan, "chan lookup", vm, randMask(), randMask(), wayIdxT'($urandom),
                  1'b0, 1'b0, 1'b0, (|vm) ? PChan : 7'b0, 1'b0, '0);
    end
    k  = wayIdxT'($urandom);
    vm = randMask() | wayBit(k);
    runAndCheck(cycCca, "cca writeback", vm, randMask() | wayBit(k), randMask(),
                wayIdxT'($urandom), 1'b0, 1'b0, 1'b0, PWb, 1'b1, lowestWay(vm));
    runAndCheck(cycCca, "cca inval", vm, randMask() & ~vm, randMask(), wayIdxT'($urandom),
                1'b0, 1'b0, 1'b0, PInval, 1'b1, lowestWay(vm));
    runAndCheck(cycCca, "cca miss", '0, randMask(), randMask(), wayIdxT'($urandom),
                1'b0, 1'b0, 1'b0, 7'b0, 1'b0, '0);
  endtask

  initial begin
    void'($urandom(32'h86d7_96ac));
    errorCount    = 0;
    rstN          = 1'b0;
    chanReq       = 1'b0;
    eboxReq       = 1'b0;
    ccaReq        = 1'b0;
    vmaRead       = 1'b0;
    cacheBit      = 1'b0;
    coreBusy      = 1'b0;
    coreDataValid = 1'b0;
    validMatch    = '0;
    anyWritten    = '0;
    wordValid     = '0;
    lru           = '0;
    repeat (3) @(posedge clk);
    #1;
    rstN = 1'b1;
    testResetPriority();
    testReadHit();
    testReadMiss();
    testWrites();
    testChanCca();
    if (errorCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
cachePkg.sv
reqArbiter.sv
wayMatch.sv
cycleSeq.sv
cacheCtl.sv
tbCacheCtl.sv

// File: Bender.yml
package:
  name: cache_ctl

sources:
  - cachePkg.sv
  - reqArbiter.sv
  - wayMatch.sv
  - cycleSeq.sv
  - cacheCtl.sv
  - target: simulation
    files:
      - tbCacheCtl.sv
